//--- spi_periph_pkg.sv
/*
 * SPI peripheral shared definitions.
 * Holds the address map, the scratch sizes and the structs
 * that carry reply bytes and subperipheral buses.
 */

package spi_periph_pkg;

    // ##########################################################################
    // address map
    // ##########################################################################

    localparam int num_sub = 2;  // scratch subperipherals.

    localparam logic [7:0] addr_chip_id = 8'hAA;
    localparam logic [7:0] chip_id      = 8'hCC;  // fixed reply for the id address.

    // entry 0 is 8'hDB, entry 1 is 8'hBB.
    localparam logic [num_sub-1:0][7:0] sub_addr = {8'hBB, 8'hDB};

    // ##########################################################################
    // scratch sizes
    // ##########################################################################

    localparam int scratch_depth = 4;  // bytes per scratch register.
    localparam int ptr_width     = 2;

    // one reply byte.
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } spi_byte_t;

    // what a scratch register sees of the frame.
    typedef struct packed {
        logic       enable;
        logic       write;  // one clock per data byte.
        logic [7:0] data;
    } sub_bus_t;

endpackage

//--- spi_target.sv
/*
 * SPI target, mode 0, MSB first.
 * Samples the pins on the system clock, assembles bytes and
 * flags the first byte of each frame as the address.
 */

`timescale 1ns/1ps

module spi_target (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      sck,
    input  logic                      cs_n,
    input  logic                      copi,
    output logic                      cipo,
    output logic [7:0]                address,
    output logic                      address_valid,
    output logic [7:0]                data,
    output logic                      data_strobe,
    input  spi_periph_pkg::spi_byte_t reply
);

    logic [1:0] sck_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] copi_sync;
    logic       sck_last;   // previous synchronized sck.
    logic       selected;
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;
    logic [7:0] rx_byte;
    logic       byte_done;
    logic       byte_strobe;
    logic       load_reply;
    logic [7:0] tx_shift;

    // ##########################################################################
    // pin synchronizer and edge detect
    // ##########################################################################

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sck_sync  <= '0;
            cs_n_sync <= '1;  // deselected.
            copi_sync <= '0;
            sck_last  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            cs_n_sync <= {cs_n_sync[0], cs_n};
            copi_sync <= {copi_sync[0], copi};
            sck_last  <= sck_sync[1];
        end
    end

    assign selected = !cs_n_sync[1];
    assign sck_rise = selected && sck_sync[1] && !sck_last;
    assign sck_fall = selected && !sck_sync[1] && sck_last;

    // ##########################################################################
    // receive
    // ##########################################################################

    assign rx_byte   = {rx_shift, copi_sync[1]};
    assign byte_done = sck_rise && (bit_count == 3'd7);  // eighth rising edge.

    // address_valid doubles as the not-first-byte flag.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_count     <= '0;
            address_valid <= 1'b0;
            data_strobe   <= 1'b0;
            byte_strobe   <= 1'b0;
        end else if (!selected) begin
            bit_count     <= '0;  // frame over or aborted mid-byte.
            address_valid <= 1'b0;
            data_strobe   <= 1'b0;
            byte_strobe   <= 1'b0;
        end else begin
            byte_strobe <= byte_done;
            data_strobe <= byte_done && address_valid;
            if (sck_rise) begin
                bit_count <= bit_count + 3'd1;
            end
            if (byte_done) begin
                address_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sck_rise) begin
            rx_shift <= rx_byte[6:0];
        end
        if (byte_done) begin
            if (address_valid) begin
                data <= rx_byte;
            end else begin
                address <= rx_byte;
            end
        end
    end

    // ##########################################################################
    // transmit
    // ##########################################################################

    // reply is taken one cycle after the strobe, once the pointer has moved.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            load_reply <= 1'b0;
            tx_shift   <= '0;
        end else if (!selected) begin
            load_reply <= 1'b0;
            tx_shift   <= '0;  // cipo idles low.
        end else begin
            load_reply <= byte_strobe;
            if (load_reply && address_valid) begin
                tx_shift <= reply.valid ? reply.data : 8'h00;
            end else if (sck_fall && bit_count != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};  // no shift on the byte's last fall.
            end
        end
    end

    assign cipo = tx_shift[7];

    // strobes only follow a completed address byte.
    strobe_after_address : assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(data_strobe) |-> address_valid
    ) else $error("data_strobe rose without a valid address");

    strobe_single_cycle : assert property (
        @(posedge clock) disable iff (!arst_n)
        data_strobe |=> !data_strobe
    ) else $error("data_strobe held for two cycles");

endmodule

//--- spi_subperipheral_selector.sv
/*
 * Subperipheral selector.
 * Decodes the address byte into the chip id reply or a single
 * subperipheral enable, and routes that reply back to the target.
 */

`timescale 1ns/1ps

module spi_subperipheral_selector (
    input  logic [7:0]                address,
    input  logic                      address_valid,

    output spi_periph_pkg::spi_byte_t reply,
    output logic [spi_periph_pkg::num_sub-1:0] enable,

    input  spi_periph_pkg::spi_byte_t [spi_periph_pkg::num_sub-1:0] sub_reply
);

    import spi_periph_pkg::*;

    // ##########################################################################
    // address decode
    // ##########################################################################

    always_comb begin
        reply  = '0;  // unmapped or no frame.
        enable = '0;

        if (address_valid) begin

            // fixed id, no subperipheral involved.
            if (address == addr_chip_id) begin
                reply.data  = chip_id;
                reply.valid = 1'b1;
            end

            for (int i = 0; i < num_sub; i++) begin
                if (address == sub_addr[i]) begin
                    enable[i] = 1'b1;
                    reply     = sub_reply[i];  // pass through as is.
                end
            end

        end
    end

    // ##########################################################################
    // checks
    // ##########################################################################

    // holds only while the address map has no duplicate entries.
    always_comb begin
        enable_onehot : assert final ($onehot0(enable))
            else $error("more than one subperipheral enabled");
    end

endmodule

//--- spi_scratch_register.sv
/*
 * Scratch subperipheral.
 * A small byte memory that returns its old contents while a
 * frame overwrites them, one byte per data strobe.
 */

`timescale 1ns/1ps

module spi_scratch_register (
    input  logic                      clock,
    input  logic                      arst_n,
    input  spi_periph_pkg::sub_bus_t  bus,
    output spi_periph_pkg::spi_byte_t reply
);

    import spi_periph_pkg::*;

    logic [7:0]           mem [scratch_depth];
    logic [ptr_width-1:0] ptr;  // next byte to read and write.

    // ##########################################################################
    // storage and pointer
    // ##########################################################################

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
            for (int i = 0; i < scratch_depth; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (!bus.enable) begin
            ptr <= '0;  // every frame starts at byte 0.
        end else if (bus.write) begin
            mem[ptr] <= bus.data;
            if (ptr == ptr_width'(scratch_depth - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // old byte at the pointer, ahead of the write.
    always_comb begin
        reply.valid = bus.enable;
        reply.data  = bus.enable ? mem[ptr] : 8'h00;
    end

    // ##########################################################################
    // checks
    // ##########################################################################

    // the top gates each write with this register's enable.
    write_needs_enable : assert property (
        @(posedge clock) disable iff (!arst_n)
        bus.write |-> bus.enable
    ) else $error("write strobe without enable");

endmodule

//--- spi_peripheral.sv
/*
 * SPI peripheral top level.
 * Connects the SPI target, the subperipheral selector and
 * the scratch subperipherals.
 */

`timescale 1ns/1ps

module spi_peripheral (
    input  logic clock,
    input  logic arst_n,
    input  logic sck,
    input  logic cs_n,
    input  logic copi,
    output logic cipo
);

    import spi_periph_pkg::*;

    logic [7:0]                address;
    logic                      address_valid;
    logic [7:0]                data;
    logic                      data_strobe;
    spi_byte_t                 reply;
    logic [num_sub-1:0]        sub_enable;
    spi_byte_t [num_sub-1:0]   sub_reply;
    sub_bus_t  [num_sub-1:0]   sub_bus;

    spi_target u_target (
        .clock         (clock),
        .arst_n        (arst_n),
        .sck           (sck),
        .cs_n          (cs_n),
        .copi          (copi),
        .cipo          (cipo),
        .address       (address),
        .address_valid (address_valid),
        .data          (data),
        .data_strobe   (data_strobe),
        .reply         (reply)
    );

    spi_subperipheral_selector u_selector (
        .address       (address),
        .address_valid (address_valid),
        .reply         (reply),
        .enable        (sub_enable),
        .sub_reply     (sub_reply)
    );

    // ##########################################################################
    // scratch subperipherals
    // ##########################################################################

    for (genvar i = 0; i < num_sub; i++) begin : g_scratch
        assign sub_bus[i] = '{enable: sub_enable[i],
                              write:  data_strobe && sub_enable[i],  // selected only.
                              data:   data};

        spi_scratch_register u_scratch (
            .clock  (clock),
            .arst_n (arst_n),
            .bus    (sub_bus[i]),
            .reply  (sub_reply[i])
        );
    end

endmodule

//--- tb_spi_peripheral.sv
/*
 * Testbench for the SPI peripheral.
 * Acts as an SPI host in mode 0, keeps a model of the scratch
 * contents and checks every received byte with assertions.
 */

`timescale 1ns/1ps

module tb_spi_peripheral;

    localparam logic [7:0] id_addr   = 8'hAA;
    localparam logic [7:0] id_reply  = 8'hCC;
    localparam logic [7:0] addr_sub0 = 8'hDB;
    localparam logic [7:0] addr_sub1 = 8'hBB;
    localparam logic [7:0] addr_none = 8'h5A;  // not in the address map.

    logic       clock;
    logic       arst_n;
    logic       sck;
    logic       cs_n;
    logic       copi;
    logic       cipo;

    string      test_name;
    int         error_count = 0;
    int         test_count  = 0;
    int         test_errors = 0;
    int         idle_count  = 0;  // clocks with cs_n high.
    bit         timed_out   = 1'b0;
    logic       byte_check  = 1'b0;
    logic [7:0] want_byte   = 8'h00;
    logic [7:0] got_byte    = 8'h00;
    logic [7:0] tx_data [$];
    logic [7:0] model_mem [2][4] = '{default: 8'h00};

    spi_peripheral UUT (
        .clock  (clock),
        .arst_n (arst_n),
        .sck    (sck),
        .cs_n   (cs_n),
        .copi   (copi),
        .cipo   (cipo)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        idle_count <= cs_n ? idle_count + 1 : 0;
    end

    // ##########################################################################
    // checks
    // ##########################################################################

    byte_matches : assert property (@(posedge clock) byte_check |-> got_byte == want_byte)
        else begin
            $display("[ERROR] %s: expected %02h, actual %02h", test_name, want_byte, got_byte);
            error_count++;
        end

    // the synchronizer needs a few clocks before cipo clears.
    cipo_idle_low : assert property (
        @(posedge clock) disable iff (!arst_n)
        idle_count >= 4 |-> !cipo
    ) else begin
        $display("[ERROR] %s: expected cipo 0 with cs_n idle, actual %b",
                 test_name, $sampled(cipo));
        error_count++;
    end

    // ##########################################################################
    // host and model
    // ##########################################################################

    task automatic tick(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    function automatic int sub_index(input logic [7:0] addr);
        if (addr == addr_sub0) begin
            return 0;
        end
        if (addr == addr_sub1) begin
            return 1;
        end
        return -1;
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        while (idle_count < 8 && n < 100) begin
            tick(1);
            n++;
        end
        if (idle_count < 8) begin
            $display("timeout while waiting for cs_n to go idle");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while ((arst_n !== 1'b1 || cipo !== 1'b0) && n < 20) begin
            tick(1);
            n++;
        end
        if (arst_n !== 1'b1 || cipo !== 1'b0) begin
            $display("timeout while waiting for the DUT to leave reset");
            timed_out = 1'b1;
        end
    endtask

    // mode 0, copi changes while sck is low, cipo sampled at the rise.
    task automatic shift_byte(input logic [7:0] tx, input int n_bits, output logic [7:0] rx);
        rx = 8'h00;
        for (int b = 7; b > 7 - n_bits; b--) begin
            copi = tx[b];
            tick(4);
            rx[b] = cipo;
            sck   = 1'b1;
            tick(4);
            sck   = 1'b0;
        end
    endtask

    task automatic check_byte(input logic [7:0] want, input logic [7:0] got);
        want_byte  = want;
        got_byte   = got;
        byte_check = 1'b1;
        tick(1);
        byte_check = 1'b0;
    endtask

    // address byte, then tx_data, then abort_bits of a cut-off byte.
    task automatic run_frame(input logic [7:0] addr, input int abort_bits);
        int         s;
        logic [7:0] want;
        logic [7:0] rx;
        s = sub_index(addr);
        wait_idle();
        if (timed_out) begin
            return;
        end
        cs_n = 1'b0;
        shift_byte(addr, 8, rx);
        check_byte(8'h00, rx);  // nothing loaded yet.
        foreach (tx_data[k]) begin
            if (addr == id_addr) begin
                want = id_reply;
            end else if (s >= 0) begin
                want = model_mem[s][k % 4];  // old byte, read before the write.
            end else begin
                want = 8'h00;
            end
            shift_byte(tx_data[k], 8, rx);
            check_byte(want, rx);
            if (s >= 0) begin
                model_mem[s][k % 4] = tx_data[k];
            end
        end
        if (abort_bits > 0) begin
            shift_byte(8'($urandom), abort_bits, rx);
        end
        tick(4);
        cs_n = 1'b1;
        copi = 1'b0;
    endtask

    task automatic fill_random(input int n);
        tx_data.delete();
        repeat (n) tx_data.push_back(8'($urandom));
    endtask

    // writes back what the model holds, so the frame only reads.
    task automatic fill_readback(input logic [7:0] addr);
        tx_data.delete();
        for (int i = 0; i < 4; i++) begin
            tx_data.push_back(model_mem[sub_index(addr)][i]);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s done, %0d errors", test_name, error_count - test_errors);
    endtask

    // ##########################################################################
    // test sequence
    // ##########################################################################

    initial begin
        arst_n = 1'b0;
        sck    = 1'b0;
        cs_n   = 1'b1;
        copi   = 1'b0;
        void'($urandom(32'h516c892a));
        repeat (2) @(posedge clock);
        #1 arst_n = 1'b1;

        start_test("reset");
        wait_reset_release();
        fill_readback(addr_sub0);
        run_frame(addr_sub0, 0);
        fill_readback(addr_sub1);
        run_frame(addr_sub1, 0);
        end_test();

        start_test("chip_id");
        fill_random(3);
        run_frame(id_addr, 0);
        end_test();

        start_test("round_trip");
        for (int i = 0; i < 2; i++) begin
            fill_random(4);
            run_frame(i == 0 ? addr_sub0 : addr_sub1, 0);
            fill_readback(i == 0 ? addr_sub0 : addr_sub1);
            run_frame(i == 0 ? addr_sub0 : addr_sub1, 0);
        end
        end_test();

        start_test("isolation");
        fill_random(4);
        run_frame(addr_sub0, 0);
        fill_readback(addr_sub1);
        run_frame(addr_sub1, 0);
        fill_random(4);
        run_frame(addr_sub1, 0);
        fill_readback(addr_sub0);
        run_frame(addr_sub0, 0);
        end_test();

        start_test("unknown_address");
        fill_random(4);
        run_frame(addr_none, 0);
        fill_readback(addr_sub0);
        run_frame(addr_sub0, 0);
        fill_readback(addr_sub1);
        run_frame(addr_sub1, 0);
        end_test();

        start_test("wrap_and_abort");
        fill_random(6);
        run_frame(addr_sub0, 0);  // bytes 4 and 5 land on 0 and 1.
        fill_readback(addr_sub0);
        run_frame(addr_sub0, 0);
        fill_random(2);
        run_frame(addr_sub1, 3);  // cut three bits into the third byte.
        fill_readback(addr_sub1);
        run_frame(addr_sub1, 0);
        end_test();

        $display("%0d tests, %0d errors", test_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- spi_peripheral.f
spi_periph_pkg.sv
spi_target.sv
spi_subperipheral_selector.sv
spi_scratch_register.sv
spi_peripheral.sv
tb_spi_peripheral.sv
